// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build z80CoreTb with Verilator, run it and search $(LOG) for the pass line"
	@echo "make clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --assert --top-module z80CoreTb -Mdir build -o z80CoreTb -f z80GroupZero.f
	./build/z80CoreTb > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf build $(LOG)

// File: bench/clockGen.sv
// Free-running 40 ns clock; rstN is held low over the first three rising edges.
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // release a little after the edge, like every other driven input.
    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        #2 rstN = 1'b1;
    end

endmodule

// File: bench/z80CoreTb.sv
// Expected values come from a model of the 00-quarter rules; stops at the first mismatch.
`timescale 1ns/1ps

module z80CoreTb;

    localparam int maxEntries = 64;
    localparam int scriptLen = 37;

    // each word is {readSel, opcode, operand}; the operand only matters for the z=6 loads.
    localparam logic [18:0] script [scriptLen] = '{
        {3'd6, 8'h37, 8'h00}, {3'd0, 8'h06, 8'hFF}, {3'd0, 8'h04, 8'h00}, {3'd0, 8'h05, 8'h00},
        {3'd6, 8'h3F, 8'h00}, {3'd7, 8'h3E, 8'h7F}, {3'd7, 8'h3C, 8'h00}, {3'd1, 8'h0E, 8'h00},
        {3'd1, 8'h0D, 8'h00}, {3'd0, 8'h06, 8'h12}, {3'd0, 8'h03, 8'h00}, {3'd1, 8'h0B, 8'h00},
        {3'd2, 8'h16, 8'h00}, {3'd3, 8'h1E, 8'h00}, {3'd2, 8'h1B, 8'h00}, {3'd3, 8'h13, 8'h00},
        {3'd3, 8'h1E, 8'h01}, {3'd3, 8'h1D, 8'h00}, {3'd4, 8'h26, 8'hFF}, {3'd5, 8'h2E, 8'hFF},
        {3'd4, 8'h23, 8'h00}, {3'd5, 8'h2B, 8'h00}, {3'd7, 8'h3E, 8'h5A}, {3'd7, 8'h2F, 8'h00},
        {3'd6, 8'h37, 8'h00}, {3'd6, 8'h37, 8'h00}, {3'd6, 8'h3F, 8'h00}, {3'd6, 8'h3F, 8'h00},
        {3'd6, 8'h36, 8'h99}, {3'd7, 8'h33, 8'h00}, {3'd4, 8'h3B, 8'h00}, {3'd6, 8'h34, 8'h00},
        {3'd0, 8'h40, 8'h00}, {3'd1, 8'h08, 8'h00}, {3'd7, 8'h07, 8'h00}, {3'd5, 8'hC9, 8'h00},
        {3'd7, 8'h00, 8'h00}
    };

    logic clk;
    logic rstN;
    logic byteValid;
    logic [7:0] byteIn;
    logic [2:0] readSel;
    logic [7:0] readData;
    logic [2:0] flags;
    logic busy;
    logic unsupported;

    logic [7:0] tblOpcode [maxEntries];
    logic [7:0] tblOperand [maxEntries];
    logic [2:0] tblReadSel [maxEntries];
    logic [7:0] tblValue [maxEntries];
    logic [2:0] tblFlags [maxEntries];
    logic tblUnsupported [maxEntries];
    logic [7:0] model [8];
    int entryCount = 0;
    int cycleCount = 0;
    int cycleLimit = 0;
    int failCount = 0;
    int seed = 32'h9bd0_fdc1;

    clockGen clockGen_inst (.clk(clk), .rstN(rstN));

    z80Core z80Core_inst (
        .clk(clk), .rstN(rstN), .byteValid(byteValid), .byteIn(byteIn), .readSel(readSel),
        .readData(readData), .flags(flags), .busy(busy), .unsupported(unsupported)
    );

    bind z80Core z80CoreProperties z80CoreProperties_inst (
        .clk(clk), .rstN(rstN), .busy(busy), .pairOp(pairOp), .writeReg(writeReg),
        .opcode(opcode)
    );

    task automatic checkValue(input logic [7:0] actual, input logic [7:0] expected,
                              input string what);
        if (actual !== expected) begin
            failCount++;
            $display("Fail at time %0t: %s, read %h, expected %h", $time, what, actual, expected);
            $display("Something failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // runs one opcode through the model; F sits in slot 6 as {S, Z, 5'b0, C}.
    task automatic addEntry(input logic [7:0] op, input logic [7:0] operandByte,
                            input logic [2:0] sel);
        logic [2:0] y;
        logic [1:0] p;
        logic [15:0] pairValue;
        logic unsup;
        y = op[5:3];
        p = op[5:4];
        pairValue = {model[{p, 1'b0}], model[{p, 1'b1}]} + (op[3] ? 16'hFFFF : 16'h0001);
        unsup = 1'b1;
        if (op[7:6] == 2'd0) begin
            case (op[2:0])
                3'd0: unsup = (y != 3'd0);
                3'd3: begin
                    unsup = (p == 2'd3);
                    if (!unsup) begin
                        model[{p, 1'b0}] = pairValue[15:8];
                        model[{p, 1'b1}] = pairValue[7:0];
                    end
                end
                3'd4, 3'd5, 3'd6: begin
                    unsup = (y == 3'd6);
                    if (!unsup && op[2:0] == 3'd6) begin
                        model[y] = operandByte;
                    end else if (!unsup) begin
                        model[y] = model[y] + (op[0] ? 8'hFF : 8'h01);
                        model[6][7] = model[y][7];
                        model[6][6] = (model[y] == 8'h00);
                    end
                end
                3'd7: begin
                    unsup = (y < 3'd5);
                    if (y == 3'd5) begin
                        model[7] = ~model[7];
                    end else if (y == 3'd6) begin
                        model[6][0] = 1'b1;
                    end else if (y == 3'd7) begin
                        model[6][0] = ~model[6][0];
                    end
                end
                default: unsup = 1'b1;
            endcase
        end
        tblOpcode[entryCount] = op;
        tblOperand[entryCount] = operandByte;
        tblReadSel[entryCount] = sel;
        tblValue[entryCount] = model[sel];
        tblFlags[entryCount] = {model[6][7], model[6][6], model[6][0]};
        tblUnsupported[entryCount] = unsup;
        entryCount++;
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit != 0 && cycleCount > cycleLimit) begin
            $display("Timeout: the DUT hung, busy never fell within %0d cycles", cycleLimit);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        byteValid = 1'b0;
        byteIn = 8'h00;
        readSel = 3'd0;
        for (int r = 0; r < 8; r++) begin
            model[r] = 8'h00;
        end
        for (int r = 0; r < 8; r++) begin
            if (r != 6) begin
                addEntry(8'(8 * r + 6), 8'($random(seed)), 3'(r));
            end
        end
        for (int i = 0; i < scriptLen; i++) begin
            addEntry(script[i][15:8], script[i][7:0], script[i][18:16]);
        end
        cycleLimit = 4 * entryCount + 20;

        @(posedge rstN);
        @(posedge clk);
        #2;
        checkValue(8'(busy), 8'h00, "busy after reset");
        checkValue(8'(flags), 8'h00, "flags after reset");
        for (int r = 0; r < 8; r++) begin
            readSel = 3'(r);
            #1;
            checkValue(readData, 8'h00, $sformatf("register %0d after reset", r));
        end

        for (int i = 0; i < entryCount; i++) begin
            byteValid = 1'b1;
            byteIn = tblOpcode[i];
            @(posedge clk);
            #2;
            // x=0, z=6 waits in phase 1 for its operand byte.
            byteValid = (tblOpcode[i][7:6] == 2'd0) && (tblOpcode[i][2:0] == 3'd6);
            byteIn = tblOperand[i];
            @(negedge clk);
            checkValue(8'(unsupported), 8'(tblUnsupported[i]),
                       $sformatf("entry %0d unsupported pulse", i));
            while (busy) begin
                @(posedge clk);
                #2;
            end
            byteValid = 1'b0;
            readSel = tblReadSel[i];
            #1;
            checkValue(8'(unsupported), 8'h00, $sformatf("entry %0d unsupported after end", i));
            checkValue(readData, tblValue[i], $sformatf("entry %0d register readback", i));
            checkValue(8'(flags), 8'(tblFlags[i]), $sformatf("entry %0d flags", i));
        end

        if (failCount == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "mismatches were found");
        end
    end

endmodule

// File: bench/z80Core_properties.sv
// Checks write strobes and busy timing only; register contents are left to the testbench.
`timescale 1ns/1ps

module z80CoreProperties import z80CorePkg::*; (
    input logic       clk,
    input logic       rstN,
    input logic       busy,
    input logic       pairOp,
    input logic [7:0] writeReg,
    input opcodeT     opcode
);

    logic needsOperand;

    assign needsOperand = (opcode.fields.x == 2'd0) && (opcode.fields.z == 3'd6);

    // a pair write raises both halves, every other write touches at most one register.
    writeOneHot: assert property (@(posedge clk) disable iff (!rstN)
        !pairOp |-> $onehot0(writeReg))
        else $error("writeReg has several bits set outside a pair write");

    busyAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !busy)
        else $error("busy is high in the first cycle after reset");

    singleCycleBusy: assert property (@(posedge clk) disable iff (!rstN)
        ($rose(busy) && !needsOperand) |=> !busy)
        else $error("an instruction without operand held busy for more than one cycle");

endmodule

// File: source/aluUnit.sv
// Only S, Z and C exist; flagsIn is packed as {S, Z, C} and other F bits come out as zero.
`timescale 1ns/1ps
`include "z80Core_macros.svh"

module aluUnit import z80CorePkg::*; (
    input  logic [`ALU_OP_WIDTH-1:0]  aluOp,
    input  logic                      pairOp,
    input  logic [`DATA_WIDTH-1:0]    srcData,
    input  logic [2*`DATA_WIDTH-1:0]  pairData,
    input  logic [2:0]                flagsIn,
    input  opcodeT                    opcode,
    output logic [`DATA_WIDTH-1:0]    result,
    output logic [2*`DATA_WIDTH-1:0]  pairResult,
    output logic [`DATA_WIDTH-1:0]    flagsOut
);

    logic carryOp;
    logic stepOp;

    // x=0, z=7 reaching the ALU with flags enabled is SCF or CCF.
    assign carryOp = !pairOp && (aluOp == `ALU_PASS)
                   && (opcode.fields.x == 2'd0) && (opcode.fields.z == 3'd7);
    assign stepOp = !pairOp && ((aluOp == `ALU_INC) || (aluOp == `ALU_DEC));

    always_comb begin
        case (aluOp)
            `ALU_INC: result = srcData + `DATA_WIDTH'(1);
            `ALU_DEC: result = srcData - `DATA_WIDTH'(1);
            `ALU_CPL: result = ~srcData;
            default: result = srcData;
        endcase
    end

    assign pairResult = !pairOp ? pairData
                      : (aluOp == `ALU_DEC) ? pairData - (2*`DATA_WIDTH)'(1)
                      : pairData + (2*`DATA_WIDTH)'(1);

    always_comb begin
        flagsOut = '0;
        flagsOut[`FLAG_S] = flagsIn[2];
        flagsOut[`FLAG_Z] = flagsIn[1];
        flagsOut[`FLAG_C] = flagsIn[0];
        if (stepOp) begin
            flagsOut[`FLAG_S] = result[`DATA_WIDTH-1];
            flagsOut[`FLAG_Z] = (result == '0);
        end
        if (carryOp) begin
            // opcode bit 3 is clear for SCF and set for CCF.
            flagsOut[`FLAG_C] = opcode.fields.y[0] ? !flagsIn[0] : 1'b1;
        end
    end

endmodule

// File: source/decodeAccumulatorOps.sv
// Covers NOP, CPL, SCF and CCF; every other code routed here just ends as unsupported.
`timescale 1ns/1ps
`include "z80Core_macros.svh"

module decodeAccumulatorOps import z80CorePkg::*; (
    input  logic                     enable,
    input  opcodeT                   opcode,
    output logic [`ALU_OP_WIDTH-1:0] aluOp,
    output logic [7:0]               writeReg,
    output logic                     writeFlags,
    output logic                     resetPhase,
    output logic                     unsupported
);

    logic quarterZero;

    assign quarterZero = (opcode.fields.x == 2'd0);

    always_comb begin
        aluOp = `ALU_PASS;
        writeReg = '0;
        writeFlags = 1'b0;
        resetPhase = 1'b0;
        unsupported = 1'b0;
        if (enable) begin
            resetPhase = 1'b1;
            if (quarterZero && (opcode.fields.z == 3'd7) && (opcode.fields.y == 3'd5)) begin
                aluOp = `ALU_CPL;
                writeReg = 8'b0000_0001 << `REG_A;
            end else if (quarterZero && (opcode.fields.z == 3'd7)
                         && (opcode.fields.y[2:1] == 2'b11)) begin
                // SCF and CCF, told apart later by the ALU.
                writeFlags = 1'b1;
            end else if (!(quarterZero && (opcode.fields.z == 3'd0)
                           && (opcode.fields.y == 3'd0))) begin
                unsupported = 1'b1;
            end
        end
    end

endmodule

// File: source/decodeGroupZero.sv
// Top decoder of the 00 quarter; all strobes are zero unless execute is high in phase 1.
`timescale 1ns/1ps
`include "z80Core_macros.svh"

module decodeGroupZero import z80CorePkg::*; (
    input  opcodeT                   opcode,
    input  logic [`PHASE_WIDTH-1:0]  phase,
    input  logic                     execute,
    output logic [`ALU_OP_WIDTH-1:0] aluOp,
    output logic                     pairOp,
    output logic [2:0]               srcSel,
    output logic [1:0]               pairSel,
    output logic [7:0]               writeReg,
    output logic                     writeFlags,
    output logic                     loadOperand,
    output logic                     resetPhase,
    output logic                     unsupported
);

    logic active;
    logic zHigh;
    logic zLow;
    logic regEnable;
    logic accEnable;

    logic [`ALU_OP_WIDTH-1:0] regAluOp;
    logic [2:0] regSrcSel;
    logic [7:0] regWriteReg;
    logic regWriteFlags;
    logic regResetPhase;
    logic regUnsupported;

    logic [`ALU_OP_WIDTH-1:0] accAluOp;
    logic [7:0] accWriteReg;
    logic accWriteFlags;
    logic accResetPhase;
    logic accUnsupported;

    assign active = execute && (phase == `PHASE_WIDTH'(1));

    // first split on z[2], then trim z=7 off the upper half and keep only z=3 of the lower.
    assign zHigh = active && opcode.fields.z[2];
    assign zLow = active && !opcode.fields.z[2];
    assign regEnable = (opcode.fields.x == 2'd0)
                     && ((zHigh && (opcode.fields.z[1:0] != 2'b11))
                      || (zLow && (opcode.fields.z[1:0] == 2'b11)));
    assign accEnable = active && !regEnable;

    decodeRegisterOps decodeRegisterOps_inst (
        .enable(regEnable),
        .opcode(opcode),
        .aluOp(regAluOp),
        .pairOp(pairOp),
        .srcSel(regSrcSel),
        .pairSel(pairSel),
        .writeReg(regWriteReg),
        .writeFlags(regWriteFlags),
        .loadOperand(loadOperand),
        .resetPhase(regResetPhase),
        .unsupported(regUnsupported)
    );

    decodeAccumulatorOps decodeAccumulatorOps_inst (
        .enable(accEnable),
        .opcode(opcode),
        .aluOp(accAluOp),
        .writeReg(accWriteReg),
        .writeFlags(accWriteFlags),
        .resetPhase(accResetPhase),
        .unsupported(accUnsupported)
    );

    assign writeReg = regWriteReg | accWriteReg;
    assign writeFlags = regWriteFlags | accWriteFlags;
    assign resetPhase = regResetPhase | accResetPhase;
    assign unsupported = regUnsupported | accUnsupported;

    // accumulator operations always read A.
    assign aluOp = regEnable ? regAluOp : accAluOp;
    assign srcSel = accEnable ? 3'(`REG_A) : regSrcSel;

endmodule

// File: source/decodeRegisterOps.sv
// Handles z=3..6 of x=0 only; the (HL) and SP forms end as unsupported without any write.
`timescale 1ns/1ps
`include "z80Core_macros.svh"

module decodeRegisterOps import z80CorePkg::*; (
    input  logic                     enable,
    input  opcodeT                   opcode,
    output logic [`ALU_OP_WIDTH-1:0] aluOp,
    output logic                     pairOp,
    output logic [2:0]               srcSel,
    output logic [1:0]               pairSel,
    output logic [7:0]               writeReg,
    output logic                     writeFlags,
    output logic                     loadOperand,
    output logic                     resetPhase,
    output logic                     unsupported
);

    logic memorySlot;
    logic stackPair;

    assign memorySlot = (opcode.fields.y == 3'd6);
    assign stackPair = (opcode.pair.p == 2'd3);

    // register selects follow the opcode, only the strobes depend on enable.
    assign srcSel = opcode.fields.y;
    assign pairSel = opcode.pair.p;

    always_comb begin
        aluOp = `ALU_PASS;
        pairOp = 1'b0;
        writeReg = '0;
        writeFlags = 1'b0;
        loadOperand = 1'b0;
        resetPhase = 1'b0;
        unsupported = 1'b0;
        if (enable) begin
            resetPhase = 1'b1;
            case (opcode.fields.z)
                3'd3: begin
                    // pair p occupies registers 2p (high) and 2p+1 (low).
                    if (stackPair) begin
                        unsupported = 1'b1;
                    end else begin
                        pairOp = 1'b1;
                        aluOp = opcode.pair.q ? `ALU_DEC : `ALU_INC;
                        writeReg = 8'b0000_0011 << {opcode.pair.p, 1'b0};
                    end
                end
                3'd4, 3'd5: begin
                    if (memorySlot) begin
                        unsupported = 1'b1;
                    end else begin
                        aluOp = opcode.fields.z[0] ? `ALU_DEC : `ALU_INC;
                        writeReg = 8'b0000_0001 << opcode.fields.y;
                        writeFlags = 1'b1;
                    end
                end
                3'd6: begin
                    if (memorySlot) begin
                        unsupported = 1'b1;
                    end else begin
                        loadOperand = 1'b1;
                        writeReg = 8'b0000_0001 << opcode.fields.y;
                    end
                end
                default: begin
                    unsupported = 1'b1;
                end
            endcase
        end
    end

endmodule

// File: source/instructionSequencer.sv
// One instruction in flight; bytes are taken only while idle or while LD r,n waits for its operand.
`timescale 1ns/1ps
`include "z80Core_macros.svh"

module instructionSequencer import z80CorePkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    byteValid,
    input  logic [`DATA_WIDTH-1:0]  byteIn,
    input  logic                    resetPhase,
    output opcodeT                  opcode,
    output logic [`DATA_WIDTH-1:0]  operand,
    output logic [`PHASE_WIDTH-1:0] phase,
    output logic                    execute,
    output logic                    busy
);

    logic needsOperand;
    logic inPhaseOne;
    logic accept;

    assign busy = (phase != '0);
    assign accept = byteValid && !busy;
    assign inPhaseOne = (phase == `PHASE_WIDTH'(1));

    // the LD r,n pattern holds phase 1 until the operand byte shows up.
    assign needsOperand = (opcode.fields.x == 2'd0) && (opcode.fields.z == 3'd6);
    assign execute = inPhaseOne && (!needsOperand || byteValid);

    // the operand is written in the cycle it arrives, so it passes straight through.
    assign operand = byteIn;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            opcode <= '0;
            phase <= '0;
        end else if (accept) begin
            opcode <= opcodeT'(byteIn);
            phase <= `PHASE_WIDTH'(1);
        end else if (resetPhase) begin
            phase <= '0;
        end
    end

endmodule

// File: source/registerFile.sv
// Index 6 holds F instead of (HL); a flag write wins over any byte write to that slot.
`timescale 1ns/1ps
`include "z80Core_macros.svh"

module registerFile (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [7:0]                writeReg,
    input  logic                      writeFlags,
    input  logic [`DATA_WIDTH-1:0]    writeData,
    input  logic                      pairWrite,
    input  logic [1:0]                pairSel,
    input  logic [2*`DATA_WIDTH-1:0]  pairData,
    input  logic [`DATA_WIDTH-1:0]    flagsData,
    input  logic [2:0]                srcSel,
    input  logic [2:0]                readSel,
    output logic [`DATA_WIDTH-1:0]    srcData,
    output logic [2*`DATA_WIDTH-1:0]  pairOut,
    output logic [`DATA_WIDTH-1:0]    readData,
    output logic [2:0]                flags
);

    logic [`DATA_WIDTH-1:0] regs [8];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 8; i++) begin
                if (writeReg[i]) begin
                    // odd indices are the low half of a pair.
                    if (pairWrite) begin
                        regs[i] <= (i % 2 == 1) ? pairData[`DATA_WIDTH-1:0]
                                                : pairData[2*`DATA_WIDTH-1:`DATA_WIDTH];
                    end else begin
                        regs[i] <= writeData;
                    end
                end
            end
            if (writeFlags) begin
                regs[`REG_F] <= flagsData;
            end
        end
    end

    assign srcData = regs[srcSel];
    assign pairOut = {regs[{pairSel, 1'b0}], regs[{pairSel, 1'b1}]};
    assign readData = regs[readSel];
    assign flags = {regs[`REG_F][`FLAG_S], regs[`REG_F][`FLAG_Z], regs[`REG_F][`FLAG_C]};

endmodule

// File: source/z80Core.sv
// No handshake beyond busy; bytes offered while busy are dropped unless an operand is due.
`timescale 1ns/1ps
`include "z80Core_macros.svh"

module z80Core import z80CorePkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   byteValid,
    input  logic [`DATA_WIDTH-1:0] byteIn,
    input  logic [2:0]             readSel,
    output logic [`DATA_WIDTH-1:0] readData,
    output logic [2:0]             flags,
    output logic                   busy,
    output logic                   unsupported
);

    opcodeT opcode;
    logic [`DATA_WIDTH-1:0] operand;
    logic [`PHASE_WIDTH-1:0] phase;
    logic execute;
    logic resetPhase;
    logic [`ALU_OP_WIDTH-1:0] aluOp;
    logic pairOp;
    logic [2:0] srcSel;
    logic [1:0] pairSel;
    logic [7:0] writeReg;
    logic writeFlags;
    logic loadOperand;
    logic [`DATA_WIDTH-1:0] srcData;
    logic [2*`DATA_WIDTH-1:0] pairOut;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic [2*`DATA_WIDTH-1:0] pairResult;
    logic [`DATA_WIDTH-1:0] flagsOut;
    logic [`DATA_WIDTH-1:0] writeData;

    instructionSequencer instructionSequencer_inst (
        .clk(clk), .rstN(rstN), .byteValid(byteValid), .byteIn(byteIn),
        .resetPhase(resetPhase), .opcode(opcode), .operand(operand),
        .phase(phase), .execute(execute), .busy(busy)
    );

    decodeGroupZero decodeGroupZero_inst (
        .opcode(opcode), .phase(phase), .execute(execute), .aluOp(aluOp),
        .pairOp(pairOp), .srcSel(srcSel), .pairSel(pairSel), .writeReg(writeReg),
        .writeFlags(writeFlags), .loadOperand(loadOperand),
        .resetPhase(resetPhase), .unsupported(unsupported)
    );

    aluUnit aluUnit_inst (
        .aluOp(aluOp), .pairOp(pairOp), .srcData(srcData), .pairData(pairOut),
        .flagsIn(flags), .opcode(opcode), .result(aluResult),
        .pairResult(pairResult), .flagsOut(flagsOut)
    );

    // LD r,n writes the operand byte instead of the ALU result.
    assign writeData = loadOperand ? operand : aluResult;

    registerFile registerFile_inst (
        .clk(clk), .rstN(rstN), .writeReg(writeReg), .writeFlags(writeFlags),
        .writeData(writeData), .pairWrite(pairOp), .pairSel(pairSel),
        .pairData(pairResult), .flagsData(flagsOut), .srcSel(srcSel),
        .readSel(readSel), .srcData(srcData), .pairOut(pairOut),
        .readData(readData), .flags(flags)
    );

endmodule

// File: source/z80CorePkg.sv
// Opcode views for the 00 quarter only; both structs overlay the same 8-bit opcode byte.
package z80CorePkg;

    // y/z view, used for single-register operations.
    typedef struct packed {
        logic [1:0] x;
        logic [2:0] y;
        logic [2:0] z;
    } opcodeFieldsT;

    // p/q view, used for register-pair operations.
    typedef struct packed {
        logic [1:0] x;
        logic [1:0] p;
        logic       q;
        logic [2:0] z;
    } opcodePairT;

    typedef union packed {
        opcodeFieldsT fields;
        opcodePairT   pair;
    } opcodeT;

endpackage

// File: source/z80Core_macros.svh
// Widths and encodings are fixed for the 00 opcode quarter; changing DATA_WIDTH is not supported.
`ifndef Z80CORE_MACROS_SVH
`define Z80CORE_MACROS_SVH

`define DATA_WIDTH 8
`define PHASE_WIDTH 2
`define ALU_OP_WIDTH 2

`define ALU_PASS 2'd0
`define ALU_INC 2'd1
`define ALU_DEC 2'd2
`define ALU_CPL 2'd3

// bit positions inside the F register.
`define FLAG_S 7
`define FLAG_Z 6
`define FLAG_C 0

`define REG_F 6
`define REG_A 7

`endif

// File: z80GroupZero.f
+incdir+source
source/z80CorePkg.sv
source/instructionSequencer.sv
source/decodeRegisterOps.sv
source/decodeAccumulatorOps.sv
source/decodeGroupZero.sv
source/aluUnit.sv
source/registerFile.sv
source/z80Core.sv
bench/clockGen.sv
bench/z80Core_properties.sv
bench/z80CoreTb.sv
